//--- src.f
+incdir+include
verilog/pe_array_pkg.sv
verilog/load_distributor.sv
verilog/pe.sv
verilog/piso_out.sv
verilog/pe_array.sv
tb/pe_array_properties.sv
tb/pe_array_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module pe_array_tb \
		-o pe_array_sim

run: compile
	./obj_dir/pe_array_sim | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/pe_array_tb.sv
`include "pe_array_params.svh"

module pe_array_tb
    import pe_array_pkg::*;
();

    localparam int WORDS    = `PE_NUM * `LOAD_NUM;
    localparam int NUM_ROWS = 7;

    typedef enum logic [1:0] {
        MODE_RAND,
        MODE_MAX,
        MODE_MIN
    } op_mode_t;

    // One test: burst, operand mode, gap before load, reload while shifting
    typedef struct packed {
        logic [4:0] burst_len;
        op_mode_t   mode;
        logic [4:0] load_delay;
        logic       reload;
    } test_row_t;

    logic  clk;
    logic  rst_n;
    logic  din_v;
    cplx_t din;
    logic  load;
    logic  dout_v;
    cplx_t dout;

    integer    seed = 32'h3876df18;
    int        cycle_cnt = 0;
    int        timeout_limit;
    test_row_t table_rows [NUM_ROWS];

    // Reference model, operands persist across bursts
    cplx_t model_a [`PE_NUM];
    cplx_t model_b [`PE_NUM];
    cplx_t exp_sums [`PE_NUM];

    pe_array UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .din_v  (din_v),
        .din    (din),
        .load   (load),
        .dout_v (dout_v),
        .dout   (dout)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by the watchdog");
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic cplx_t make_word(input op_mode_t mode);
        logic [31:0] r;
        cplx_t       w;
        r = $random(seed);
        w = r[15:0];
        if (mode == MODE_MAX) begin
            w.re = 8'h7f;
            w.im = 8'h7f;
        end else if (mode == MODE_MIN) begin
            w.re = 8'h80;
            w.im = 8'h80;
        end
        return w;
    endfunction

    // Wrapped complex products, then prefix sums from PE 0 up
    function automatic void compute_expected();
        int re_p;
        int im_p;
        int acc_re;
        int acc_im;
        acc_re = 0;
        acc_im = 0;
        for (int i = 0; i < `PE_NUM; i++) begin
            re_p = int'(model_a[i].re) * int'(model_b[i].re)
                 - int'(model_a[i].im) * int'(model_b[i].im);
            im_p = int'(model_a[i].re) * int'(model_b[i].im)
                 + int'(model_a[i].im) * int'(model_b[i].re);
            acc_re = (acc_re + re_p) & 'hff;
            acc_im = (acc_im + im_p) & 'hff;
            exp_sums[i].re = acc_re[7:0];
            exp_sums[i].im = acc_im[7:0];
        end
    endfunction

    // Words past the last PE are dropped by the model too
    task automatic send_burst(input int len, input op_mode_t mode);
        cplx_t w;
        for (int k = 0; k < len; k++) begin
            w = make_word(mode);
            @(posedge clk);
            din_v <= 1'b1;
            din   <= w;
            if (k < WORDS) begin
                if (k % `LOAD_NUM == 0)
                    model_a[k / `LOAD_NUM] = w;
                else
                    model_b[k / `LOAD_NUM] = w;
            end
        end
        @(posedge clk);
        din_v <= 1'b0;
        din   <= '0;
    endtask

    task automatic pulse_load();
        @(posedge clk);
        load <= 1'b1;
        @(posedge clk);
        load <= 1'b0;
    endtask

    // Output starts in the cycle right after the sampled load
    task automatic read_outputs(input int n);
        for (int j = 0; j < n; j++) begin
            @(negedge clk);
            check_value("dout_v", dout_v, 16'd1);
            check_value($sformatf("dout word %0d", j), dout, exp_sums[j]);
        end
    endtask

    function automatic int calc_limit();
        int total;
        total = 60;
        for (int r = 0; r < NUM_ROWS; r++)
            total += table_rows[r].burst_len + table_rows[r].load_delay + 3 * `PE_NUM + 12;
        return 2 * total;
    endfunction

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        test_row_t row;
        rst_n = 1'b0;
        din_v = 1'b0;
        din   = '0;
        load  = 1'b0;
        for (int i = 0; i < `PE_NUM; i++) begin
            model_a[i] = '0;
            model_b[i] = '0;
        end

        // Full, short, overlong, max, min, and two reload rows
        table_rows[0] = '{5'd8,  MODE_RAND, 5'd6,  1'b0};
        table_rows[1] = '{5'd3,  MODE_RAND, 5'd7,  1'b0};
        table_rows[2] = '{5'd11, MODE_RAND, 5'd6,  1'b0};
        table_rows[3] = '{5'd8,  MODE_MAX,  5'd8,  1'b0};
        table_rows[4] = '{5'd8,  MODE_MIN,  5'd6,  1'b0};
        table_rows[5] = '{5'd8,  MODE_RAND, 5'd9,  1'b1};
        table_rows[6] = '{5'd5,  MODE_MAX,  5'd10, 1'b1};
        timeout_limit = calc_limit();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Idle after reset, no load given
        repeat (8) begin
            @(negedge clk);
            check_value("dout_v", dout_v, 16'd0);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = table_rows[r];
            send_burst(row.burst_len, row.mode);
            compute_expected();
            repeat (row.load_delay) @(posedge clk);
            pulse_load();
            if (row.reload) begin
                read_outputs(2);
                pulse_load();
            end
            read_outputs(`PE_NUM);
            @(negedge clk);
            check_value("dout_v", dout_v, 16'd0);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- tb/pe_array_properties.sv
`include "pe_array_params.svh"

module pe_array_props
    import pe_array_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        load,
    input logic        dout_v,
    input piso_state_t state
);

    // Output cycles since the last load
    int run_len;

    always_ff @(posedge clk) begin
        if (!rst_n)
            run_len <= 0;
        else if (load || !dout_v)
            run_len <= 0;
        else
            run_len <= run_len + 1;
    end

    load_starts_output: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> dout_v)
        else $error("dout_v did not rise after load");

    output_run_length: assert property (@(posedge clk) disable iff (!rst_n)
        dout_v |-> (run_len < `PE_NUM))
        else $error("dout_v high for more than PE_NUM cycles after a load");

    reset_clears_output: assert property (@(posedge clk)
        !rst_n |=> !dout_v)
        else $error("dout_v high after reset");

    idle_stays_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == PISO_IDLE && !load) |=> !dout_v)
        else $error("dout_v rose without a load");

endmodule

bind pe_array pe_array_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (load),
    .dout_v (dout_v),
    .state  (u_out.state)
);

//--- verilog/pe_array.sv
`include "pe_array_params.svh"

module pe_array
    import pe_array_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  din_v,
    input  cplx_t din,
    input  logic  load,
    output logic  dout_v,
    output cplx_t dout
);

    load_word_t          load_bus;
    cplx_t [`PE_NUM-1:0] sums;

    load_distributor u_dist (
        .clk      (clk),
        .rst_n    (rst_n),
        .din_v    (din_v),
        .din      (din),
        .load_bus (load_bus)
    );

    ////////////////////
    // PE chain
    ////////////////////

    genvar i;
    generate
        for (i = 0; i < `PE_NUM; i++) begin : g_pe
            if (i == 0) begin : g_head
                // Head of the chain has no upstream sum
                pe #(.PE_INDEX(i)) u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .load_bus (load_bus),
                    .sum_in   (),
                    .sum_out  (sums[i])
                );
            end else begin : g_body
                pe #(.PE_INDEX(i)) u_pe (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .load_bus (load_bus),
                    .sum_in   (sums[i-1]),
                    .sum_out  (sums[i])
                );
            end
        end
    endgenerate

    piso_out u_out (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .sums   (sums),
        .dout_v (dout_v),
        .dout   (dout)
    );

endmodule

//--- verilog/piso_out.sv
`include "pe_array_params.svh"

module piso_out
    import pe_array_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load,
    input  cplx_t [`PE_NUM-1:0]     sums,
    output logic                    dout_v,
    output cplx_t                   dout
);

    localparam int IDX_W = $clog2(`PE_NUM);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`PE_NUM - 1);

    piso_state_t          state;
    logic [IDX_W-1:0]     out_cnt;
    cplx_t [`PE_NUM-1:0]  shift_q;

    // State and output count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= PISO_IDLE;
            out_cnt <= '0;
        end else if (load) begin
            // A load mid-shift simply restarts
            state   <= PISO_SHIFT;
            out_cnt <= '0;
        end else if (state == PISO_SHIFT) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == LAST_IDX)
                state <= PISO_IDLE;
        end
    end

    ////////////////////
    // Data shifter
    ////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= sums;
        end else if (state == PISO_SHIFT) begin
            for (int i = 0; i < `PE_NUM - 1; i++)
                shift_q[i] <= shift_q[i+1];
            shift_q[`PE_NUM-1] <= '0;
        end
    end

    // PE 0 sits in the lowest entry
    assign dout_v = (state == PISO_SHIFT);
    assign dout   = shift_q[0];

endmodule

//--- verilog/pe.sv
`include "pe_array_params.svh"

module pe
    import pe_array_pkg::*;
#(
    parameter int PE_INDEX = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  load_word_t load_bus,
    input  cplx_t      sum_in,
    output cplx_t      sum_out
);

    localparam int SEL_W = $clog2(`PE_NUM);
    localparam logic [SEL_W-1:0] MY_SEL = SEL_W'(PE_INDEX);
    localparam int PW = 2 * `DATA_WIDTH;

    cplx_t op_a;
    cplx_t op_b;
    cplx_t prod;
    cplx_t acc_in;
    logic  sel_hit;

    logic signed [PW-1:0] p_rr;
    logic signed [PW-1:0] p_ii;
    logic signed [PW-1:0] p_ri;
    logic signed [PW-1:0] p_ir;
    logic signed [PW-1:0] re_full;
    logic signed [PW-1:0] im_full;

    assign sel_hit = load_bus.valid && (load_bus.pe_sel == MY_SEL);

    ////////////////////
    // Operand capture
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else if (sel_hit) begin
            if (load_bus.slot == '0)
                op_a <= load_bus.data;
            else
                op_b <= load_bus.data;
        end
    end

    ////////////////////
    // Complex multiply
    ////////////////////

    assign p_rr    = op_a.re * op_b.re;
    assign p_ii    = op_a.im * op_b.im;
    assign p_ri    = op_a.re * op_b.im;
    assign p_ir    = op_a.im * op_b.re;
    assign re_full = p_rr - p_ii;
    assign im_full = p_ri + p_ir;

    // Chain head starts the prefix sum from zero
    assign acc_in = (PE_INDEX == 0) ? '0 : sum_in;

    // Only the low byte survives, everything wraps mod 2^8
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod    <= '0;
            sum_out <= '0;
        end else begin
            prod.re    <= re_full[`DATA_WIDTH-1:0];
            prod.im    <= im_full[`DATA_WIDTH-1:0];
            sum_out.re <= prod.re + acc_in.re;
            sum_out.im <= prod.im + acc_in.im;
        end
    end

endmodule

//--- verilog/load_distributor.sv
`include "pe_array_params.svh"

module load_distributor
    import pe_array_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       din_v,
    input  cplx_t      din,
    output load_word_t load_bus
);

    localparam int SEL_W = $clog2(`PE_NUM);
    localparam int SLOT_W = $clog2(`LOAD_NUM);
    localparam logic [`CNT_WIDTH-1:0] WORDS_MAX = `CNT_WIDTH'(`PE_NUM * `LOAD_NUM);
    localparam logic [`CNT_WIDTH-1:0] LOAD_N = `CNT_WIDTH'(`LOAD_NUM);

    logic [`CNT_WIDTH-1:0] word_cnt;
    logic                  in_range;
    logic [`CNT_WIDTH-1:0] pe_idx;
    logic [`CNT_WIDTH-1:0] slot_idx;

    // Word k goes to PE k/LOAD_NUM, slot k%LOAD_NUM
    assign in_range = (word_cnt < WORDS_MAX);
    assign pe_idx   = word_cnt / LOAD_N;
    assign slot_idx = word_cnt % LOAD_N;

    // Counter sticks at WORDS_MAX until the burst ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt       <= '0;
            load_bus.valid <= 1'b0;
        end else begin
            if (!din_v)
                word_cnt <= '0;
            else if (in_range)
                word_cnt <= word_cnt + 1'b1;
            load_bus.valid <= din_v && in_range;
        end
    end

    always_ff @(posedge clk) begin
        load_bus.pe_sel <= pe_idx[SEL_W-1:0];
        load_bus.slot   <= slot_idx[SLOT_W-1:0];
        load_bus.data   <= din;
    end

endmodule

//--- verilog/pe_array_pkg.sv
`include "pe_array_params.svh"

package pe_array_pkg;

    // One complex sample, real part in the upper byte
    typedef struct packed {
        logic signed [`DATA_WIDTH-1:0] re;
        logic signed [`DATA_WIDTH-1:0] im;
    } cplx_t;

    // Operand word broadcast to all PEs
    typedef struct packed {
        logic                          valid;
        logic [$clog2(`PE_NUM)-1:0]    pe_sel;
        logic [$clog2(`LOAD_NUM)-1:0]  slot;
        cplx_t                         data;
    } load_word_t;

    typedef enum logic {
        PISO_IDLE,
        PISO_SHIFT
    } piso_state_t;

endpackage

//--- include/pe_array_params.svh
`ifndef PE_ARRAY_PARAMS_SVH
`define PE_ARRAY_PARAMS_SVH

// Width of one complex component (re or im)
`define DATA_WIDTH 8

// Number of processing elements in the chain
`define PE_NUM 4

// Operand words taken by each PE per burst
`define LOAD_NUM 2

// Burst word counter, holds PE_NUM*LOAD_NUM plus the saturated value
`define CNT_WIDTH 4

`endif
